// File: multicycleController.f
ctrlPkg.sv
instrDecoder.sv
stateSequencer.sv
controlWordGen.sv
multicycleController.sv
multicycleController_tb.sv

// File: Bender.yml
package:
  name: multicycleController

sources:
  - files:
      - ctrlPkg.sv
      - instrDecoder.sv
      - stateSequencer.sv
      - controlWordGen.sv
      - multicycleController.sv
  - target: simulation
    files:
      - multicycleController_tb.sv

// File: multicycleController_tb.sv
//**************************************************************************
// Directed tests for the multicycle controller. Outputs are sampled on the
// falling edge, and inputs change on the rising edge. instr changes only on
// the edge that ends fetch, so it holds steady through each instruction.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module multicycleController_tb
    import ctrlPkg::*;
;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        zero;
    ctrlT        ctrl;
    logic        halted;

    multicycleController uut (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .zero   (zero),
        .ctrl   (ctrl),
        .halted (halted)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reference class rule from raw opcode and funct3 bits
    function automatic instrClassE classOf(input logic [31:0] ins);
        instrClassE cls;
        begin
            case (ins[6:0])
                7'h03:   cls = clsLoad;
                7'h23:   cls = clsStore;
                7'h33:   cls = (ins[14:12] == 3'd3) ? clsIllegal : clsRType;
                7'h13:   cls = (ins[14:12] == 3'd3) ? clsIllegal : clsIType;
                7'h6f:   cls = clsJal;
                7'h63:   cls = clsBeq;
                7'h00:   cls = clsNop;
                default: cls = clsIllegal;
            endcase
            return cls;
        end
    endfunction

    // Immediate format per class
    function automatic immSrcE immOf(input instrClassE cls);
        begin
            if (cls == clsStore)
                return immS;
            else if (cls == clsBeq)
                return immB;
            else if (cls == clsJal)
                return immJ;
            return immI;
        end
    endfunction

    // ALU operation rule with add outside the ALU classes
    function automatic aluOpE aluOf(input logic [31:0] ins, input instrClassE cls);
        aluOpE op;
        begin
            op = aluAdd;
            if (cls == clsRType || cls == clsIType)
            begin
                case (ins[14:12])
                    3'd0:    op = (cls == clsRType && ins[30]) ? aluSub : aluAdd;
                    3'd1:    op = aluSll;
                    3'd2:    op = aluSlt;
                    3'd4:    op = aluXor;
                    3'd5:    op = aluSrl;
                    3'd6:    op = aluOr;
                    3'd7:    op = aluAnd;
                    default: op = aluAdd;
                endcase
            end
            return op;
        end
    endfunction

    // Expected control word of one state
    function automatic ctrlT expectCtrl(input stateE st, input logic [31:0] ins,
                                        input logic z);
        ctrlT       c;
        instrClassE cls;
        begin
            c   = '0;
            cls = classOf(ins);
            case (st)
                stFetch:
                begin
                    c.irWrite    = 1'b1;
                    c.pcWrite    = 1'b1;
                    c.aluSrcB    = srcBFour;
                    c.resultSrc  = rsAluResult;
                end
                stDecode, stMemAddr:
                begin
                    c.aluSrcA = (st == stDecode) ? srcAOldPc : srcAReg;
                    c.aluSrcB = srcBImm;
                    c.immSrc  = immOf(cls);
                end
                stMemRead, stMemWrite:
                begin
                    c.adrSrc   = 1'b1;
                    c.memWrite = (st == stMemWrite);
                end
                stMemWB:
                begin
                    c.resultSrc = rsData;
                    c.regWrite  = 1'b1;
                end
                stExecuteR, stExecuteI:
                begin
                    c.aluSrcA    = srcAReg;
                    c.aluSrcB    = (st == stExecuteR) ? srcBReg : srcBImm;
                    c.aluControl = aluOf(ins, cls);
                    c.immSrc     = (st == stExecuteI) ? immOf(cls) : immI;
                end
                stAluWB:
                    c.regWrite = 1'b1;
                stJal:
                begin
                    c.pcWrite = 1'b1;
                    c.aluSrcA = srcAOldPc;
                    c.aluSrcB = srcBFour;
                end
                stBeq:
                begin
                    c.aluSrcA    = srcAReg;
                    c.aluControl = aluSub;
                    c.pcWrite    = z;
                end
                // Idle and error leave every field at zero
                default: c = '0;
            endcase
            return c;
        end
    endfunction

    task automatic checkCtrl(input string testName, input ctrlT expected, input ctrlT actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected ctrl %h, actual ctrl %h", testName, expected, actual);
            $display("TB FAILED");
            $fatal(1, "control word mismatch");
        end
    endtask

    task automatic checkHalted(input string testName, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected halted %b, actual halted %b", testName, expected,
                     actual);
            $display("TB FAILED");
            $fatal(1, "halted flag mismatch");
        end
    endtask

    // Instruction with random don't-care bits
    function automatic logic [31:0] makeInstr(input logic [6:0] op, input logic [2:0] f3,
                                              input logic b5);
        logic [31:0] r;
        begin
            r        = $urandom;
            r[6:0]   = op;
            r[14:12] = f3;
            r[30]    = b5;
            return r;
        end
    endfunction

    function automatic logic randomBit();
        logic [31:0] r;
        begin
            r = $urandom;
            return r[0];
        end
    endfunction

    // Step on falling edges until the fetch word shows up
    task automatic waitFetch(input string testName);
        int cycles;
        begin
            cycles = 0;
            while (ctrl.irWrite !== 1'b1)
            begin
                if (cycles >= 10)
                begin
                    $display("Timed out waiting for the fetch state in test %s", testName);
                    $display("TB FAILED");
                    $fatal(1, "fetch timeout");
                end
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // Reset for 3 cycles then one idle cycle and fetch
    task automatic resetAndFetch(input string testName);
        begin
            @(posedge clk);
            reset <= 1'b1;
            repeat (3)
            begin
                @(negedge clk);
                checkCtrl(testName, expectCtrl(stIdle, instr, zero), ctrl);
                checkHalted(testName, 1'b0, halted);
            end
            @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            checkCtrl(testName, expectCtrl(stIdle, instr, zero), ctrl);
            checkHalted(testName, 1'b0, halted);
            @(negedge clk);
            checkCtrl(testName, expectCtrl(stFetch, instr, zero), ctrl);
            checkHalted(testName, 1'b0, halted);
        end
    endtask

    // Walk one instruction from fetch and check each control word
    task automatic runInstr(input string testName, input logic [31:0] ins, input logic z);
        instrClassE cls;
        stateE      seq [0:2];
        int         len;
        int         i;
        begin
            cls = classOf(ins);
            len = 2;
            waitFetch(testName);
            @(posedge clk);
            instr <= ins;
            zero  <= z;
            @(negedge clk);
            checkCtrl(testName, expectCtrl(stDecode, ins, z), ctrl);
            checkHalted(testName, 1'b0, halted);
            case (cls)
                clsLoad:
                begin
                    seq[0] = stMemAddr;
                    seq[1] = stMemRead;
                    seq[2] = stMemWB;
                    len    = 3;
                end
                clsStore:
                begin
                    seq[0] = stMemAddr;
                    seq[1] = stMemWrite;
                end
                clsRType, clsIType, clsJal:
                begin
                    seq[0] = (cls == clsRType) ? stExecuteR :
                             (cls == clsIType) ? stExecuteI : stJal;
                    seq[1] = stAluWB;
                end
                clsBeq:
                begin
                    seq[0] = stBeq;
                    len    = 1;
                end
                default: len = 0;
            endcase
            for (i = 0; i < len; i++)
            begin
                @(negedge clk);
                checkCtrl(testName, expectCtrl(seq[i], ins, z), ctrl);
                checkHalted(testName, 1'b0, halted);
            end
            if (cls != clsIllegal)
            begin
                @(negedge clk);
                checkCtrl({testName, " next fetch"}, expectCtrl(stFetch, ins, z), ctrl);
            end
        end
    endtask

    task automatic testReset();
        resetAndFetch("reset");
    endtask

    task automatic testLoadStore();
        begin
            runInstr("load", makeInstr(7'h03, 3'd2, randomBit()), randomBit());
            runInstr("store", makeInstr(7'h23, 3'd2, randomBit()), randomBit());
        end
    endtask

    task automatic testAluOps();
        int f;
        begin
            for (f = 0; f < 8; f++)
            begin
                if (f != 3)
                begin
                    runInstr($sformatf("rtype funct3 %0d", f),
                             makeInstr(7'h33, f[2:0], 1'b0), randomBit());
                    runInstr($sformatf("itype funct3 %0d", f),
                             makeInstr(7'h13, f[2:0], randomBit()), randomBit());
                end
            end
            runInstr("rtype sub", makeInstr(7'h33, 3'd0, 1'b1), randomBit());
            // Bit 30 set on addi is still an add
            runInstr("itype add bit30", makeInstr(7'h13, 3'd0, 1'b1), randomBit());
        end
    endtask

    task automatic testBranchJump();
        begin
            runInstr("beq taken", makeInstr(7'h63, 3'd0, randomBit()), 1'b1);
            runInstr("beq not taken", makeInstr(7'h63, 3'd0, randomBit()), 1'b0);
            runInstr("jal", makeInstr(7'h6f, 3'd5, randomBit()), randomBit());
            runInstr("nop", makeInstr(7'h00, 3'd4, randomBit()), randomBit());
        end
    endtask

    // Error word held from one cycle after decode through 20 more cycles
    task automatic checkErrorHold(input string testName, input logic [31:0] ins);
        int i;
        begin
            runInstr(testName, ins, randomBit());
            for (i = 0; i < 21; i++)
            begin
                @(negedge clk);
                checkCtrl(testName, expectCtrl(stError, ins, zero), ctrl);
                checkHalted(testName, 1'b1, halted);
            end
            resetAndFetch({testName, " reset"});
        end
    endtask

    task automatic testIllegal();
        begin
            checkErrorHold("unknown opcode", makeInstr(7'h37, 3'd0, randomBit()));
            checkErrorHold("rtype sltu", makeInstr(7'h33, 3'd3, 1'b0));
        end
    endtask

    initial
    begin
        void'($urandom(32'h5298b082));
        reset     = 1'b1;
        instr     = '0;
        zero      = 1'b0;
        testReset();
        testLoadStore();
        testAluOps();
        testBranchJump();
        testIllegal();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: multicycleController.sv
//**************************************************************************
// Control unit of the multicycle RV32I CPU.
// instr is the instruction-register output, zero the ALU flag.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module multicycleController
    import ctrlPkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [31:0] instr,
    input  wire logic        zero,
    output ctrlT             ctrl,
    output logic             halted
);

    decodeT decode;
    stateE  state;

    // Field decode of the held instruction
    instrDecoder decoder (
        .instr  (instr),
        .decode (decode)
    );

    // FSM
    stateSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (decode.instrClass),
        .state      (state)
    );

    // Moore outputs
    controlWordGen wordGen (
        .state  (state),
        .decode (decode),
        .zero   (zero),
        .ctrl   (ctrl),
        .halted (halted)
    );

endmodule

`default_nettype wire

// File: controlWordGen.sv
//**************************************************************************
// Moore output decode: state plus decode result to the control word.
// pcWrite in stBeq follows zero combinationally, nothing else does.
// Unlisted fields stay zero in every state.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module controlWordGen
    import ctrlPkg::*;
(
    input  wire stateE  state,
    input  wire decodeT decode,
    input  wire logic   zero,
    output ctrlT        ctrl,
    output logic        halted
);

    // Control word per state
    always_comb
    begin
        ctrl = idleCtrl;
        case (state)
            // PC <- PC + 4, latch instruction
            stFetch:
            begin
                ctrl.irWrite    = 1'b1;
                ctrl.pcWrite    = 1'b1;
                ctrl.aluSrcA    = srcAPc;
                ctrl.aluSrcB    = srcBFour;
                ctrl.aluControl = aluAdd;
                ctrl.resultSrc  = rsAluResult;
            end

            // Branch target oldPC + imm, speculative
            stDecode:
            begin
                ctrl.aluSrcA    = srcAOldPc;
                ctrl.aluSrcB    = srcBImm;
                ctrl.aluControl = aluAdd;
                ctrl.immSrc     = decode.immSrc;
            end

            // Effective address rs1 + imm
            stMemAddr:
            begin
                ctrl.aluSrcA    = srcAReg;
                ctrl.aluSrcB    = srcBImm;
                ctrl.aluControl = aluAdd;
                ctrl.immSrc     = decode.immSrc;
            end

            // Address from ALUOut
            stMemRead:
            begin
                ctrl.adrSrc    = 1'b1;
                ctrl.resultSrc = rsAluOut;
            end

            // rd <- memory data
            stMemWB:
            begin
                ctrl.resultSrc = rsData;
                ctrl.regWrite  = 1'b1;
            end

            // Mem[ALUOut] <- rs2
            stMemWrite:
            begin
                ctrl.adrSrc    = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.resultSrc = rsAluOut;
            end

            // rs1 op rs2
            stExecuteR:
            begin
                ctrl.aluSrcA    = srcAReg;
                ctrl.aluSrcB    = srcBReg;
                ctrl.aluControl = decode.aluOp;
            end

            // rs1 op imm
            stExecuteI:
            begin
                ctrl.aluSrcA    = srcAReg;
                ctrl.aluSrcB    = srcBImm;
                ctrl.aluControl = decode.aluOp;
                ctrl.immSrc     = decode.immSrc;
            end

            // rd <- ALUOut
            stAluWB:
            begin
                ctrl.resultSrc = rsAluOut;
                ctrl.regWrite  = 1'b1;
            end

            // PC <- target from decode, ALU forms return address
            stJal:
            begin
                ctrl.pcWrite    = 1'b1;
                ctrl.aluSrcA    = srcAOldPc;
                ctrl.aluSrcB    = srcBFour;
                ctrl.aluControl = aluAdd;
                ctrl.resultSrc  = rsAluOut;
            end

            // Compare rs1 - rs2, take branch on zero
            stBeq:
            begin
                ctrl.aluSrcA    = srcAReg;
                ctrl.aluSrcB    = srcBReg;
                ctrl.aluControl = aluSub;
                ctrl.resultSrc  = rsAluOut;
                ctrl.pcWrite    = zero;
            end

            // Idle and error keep the quiet word
            default:
            begin
                ctrl = idleCtrl;
            end
        endcase
    end

    assign halted = (state == stError);

    // Memory and register file never written in the same cycle
    noDualWrite: assert final (!(ctrl.memWrite && ctrl.regWrite));

    // Instruction latch always paired with the PC update
    irImpliesPc: assert final (!ctrl.irWrite || ctrl.pcWrite);

endmodule

`default_nettype wire

// File: stateSequencer.sv
//**************************************************************************
// Moore FSM state register for the multicycle controller.
// One state per clock; stError is left only through reset.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module stateSequencer
    import ctrlPkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire instrClassE instrClass,
    output stateE           state
);

    stateE nextState;

    // State register
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= stIdle;
        end
        else
        begin
            state <= nextState;
        end
    end

    // Next-state logic
    always_comb
    begin
        case (state)
            stIdle:   nextState = stFetch;
            stFetch:  nextState = stDecode;

            // Dispatch by instruction class
            stDecode:
            begin
                case (instrClass)
                    clsLoad:  nextState = stMemAddr;
                    clsStore: nextState = stMemAddr;
                    clsRType: nextState = stExecuteR;
                    clsIType: nextState = stExecuteI;
                    clsJal:   nextState = stJal;
                    clsBeq:   nextState = stBeq;
                    // nop skips straight to the next fetch
                    clsNop:   nextState = stFetch;
                    default:  nextState = stError;
                endcase
            end

            // Load and store split after the address
            stMemAddr:
            begin
                if (instrClass == clsLoad)
                    nextState = stMemRead;
                else
                    nextState = stMemWrite;
            end

            stMemRead:  nextState = stMemWB;

            // Last state of an instruction
            stMemWB:    nextState = stFetch;
            stMemWrite: nextState = stFetch;
            stAluWB:    nextState = stFetch;
            stBeq:      nextState = stFetch;

            // Results written back in aluWB
            stExecuteR: nextState = stAluWB;
            stExecuteI: nextState = stAluWB;
            stJal:      nextState = stAluWB;

            // Sticky until reset
            stError:    nextState = stError;
            default:    nextState = stError;
        endcase
    end

    // Register only ever holds a named state
    stateLegal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {stIdle, stFetch, stDecode, stMemAddr, stMemRead,
                      stMemWB, stMemWrite, stExecuteR, stExecuteI,
                      stAluWB, stJal, stBeq, stError}
    );

    // Illegal class in decode lands in error and stays there
    errorSticky: assert property (
        @(posedge clk) disable iff (reset)
        (state == stDecode && instrClass == clsIllegal) |=> (state == stError)[*2]
    );

endmodule

`default_nettype wire

// File: instrDecoder.sv
//**************************************************************************
// Purely combinational decode of the instruction-register word.
// instr must hold steady from decode until the next fetch.
// sltu (funct3 3) on R-type or I-type is flagged illegal.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module instrDecoder
    import ctrlPkg::*;
(
    input  wire logic [31:0] instr,
    output decodeT           decode
);

    // Instruction fields
    logic [6:0] opField;
    logic [2:0] funct3;
    logic       funct7b5;

    instrClassE instrClass;
    immSrcE     immSrc;
    aluOpE      aluOp;

    assign opField  = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // Opcode to class
    always_comb
    begin
        case (opField)
            opLoad:  instrClass = clsLoad;
            opStore: instrClass = clsStore;
            opJal:   instrClass = clsJal;
            opBeq:   instrClass = clsBeq;
            opNop:   instrClass = clsNop;
            // ALU classes lose sltu
            opRType: instrClass = (funct3 == funct3Sltu) ? clsIllegal : clsRType;
            opIType: instrClass = (funct3 == funct3Sltu) ? clsIllegal : clsIType;
            default: instrClass = clsIllegal;
        endcase
    end

    // Immediate format per class
    always_comb
    begin
        case (instrClass)
            clsStore: immSrc = immS;
            clsBeq:   immSrc = immB;
            clsJal:   immSrc = immJ;
            // Load, ALU, nop and illegal all use I format
            default:  immSrc = immI;
        endcase
    end

    // ALU operation from funct3, only for ALU classes
    always_comb
    begin
        aluOp = aluAdd;
        if (instrClass == clsRType || instrClass == clsIType)
        begin
            case (funct3)
                3'd0:
                begin
                    // sub only exists in R format
                    if (instrClass == clsRType && funct7b5)
                        aluOp = aluSub;
                    else
                        aluOp = aluAdd;
                end
                3'd1:    aluOp = aluSll;
                3'd2:    aluOp = aluSlt;
                3'd4:    aluOp = aluXor;
                3'd5:    aluOp = aluSrl;
                3'd6:    aluOp = aluOr;
                3'd7:    aluOp = aluAnd;
                // sltu already filtered out as illegal
                default: aluOp = aluAdd;
            endcase
        end
    end

    // Pack the result
    assign decode = '{
        instrClass: instrClass,
        immSrc:     immSrc,
        aluOp:      aluOp
    };

endmodule

`default_nettype wire

// File: ctrlPkg.sv
//**************************************************************************
// Shared types for the multicycle RV32I control unit.
// Opcode values follow the base RV32I map; opNop is the all-zero word.
// Every enum has its zero encoding as the first member.
//**************************************************************************
`default_nettype none

package ctrlPkg;

    // Major opcodes recognized by the decoder
    typedef enum logic [6:0] {
        opNop   = 7'b0000000,
        opLoad  = 7'b0000011,
        opIType = 7'b0010011,
        opStore = 7'b0100011,
        opRType = 7'b0110011,
        opBeq   = 7'b1100011,
        opJal   = 7'b1101111
    } opcodeE;

    // funct3 of sltu, not supported by the ALU
    localparam logic [2:0] funct3Sltu = 3'd3;

    // Instruction class after decode
    typedef enum logic [2:0] {
        clsLoad,
        clsStore,
        clsRType,
        clsIType,
        clsJal,
        clsBeq,
        clsNop,
        clsIllegal
    } instrClassE;

    // Immediate extender format
    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSrcE;

    // ALU operation code, also the aluControl field
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluXor,
        aluSrl,
        aluOr,
        aluAnd
    } aluOpE;

    // ALU operand A mux
    typedef enum logic [1:0] {
        srcAPc,
        srcAOldPc,
        srcAReg
    } srcAE;

    // ALU operand B mux
    typedef enum logic [1:0] {
        srcBReg,
        srcBImm,
        srcBFour
    } srcBE;

    // Result bus mux
    typedef enum logic [1:0] {
        rsAluOut,
        rsData,
        rsAluResult
    } resultSrcE;

    // FSM states
    typedef enum logic [3:0] {
        stIdle,
        stFetch,
        stDecode,
        stMemAddr,
        stMemRead,
        stMemWB,
        stMemWrite,
        stExecuteR,
        stExecuteI,
        stAluWB,
        stJal,
        stBeq,
        stError
    } stateE;

    // Decoder result, 8 bits
    typedef struct packed {
        instrClassE instrClass;
        immSrcE     immSrc;
        aluOpE      aluOp;
    } decodeT;

    // Datapath control word, 16 bits
    typedef struct packed {
        logic      pcWrite;
        logic      adrSrc;
        logic      memWrite;
        logic      irWrite;
        logic      regWrite;
        resultSrcE resultSrc;
        srcAE      aluSrcA;
        srcBE      aluSrcB;
        aluOpE     aluControl;
        immSrcE    immSrc;
    } ctrlT;

    // Quiet word used in idle and error
    localparam ctrlT idleCtrl = '0;

endpackage

`default_nettype wire
